/* common/cpuIsaPkg.sv */
`default_nettype none

package cpuIsaPkg;

    // --------------------------------------------------
    // field widths
    // --------------------------------------------------
    localparam int DATA_W     = 32;             // data and instruction word
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int REG_COUNT  = 2 ** REG_ADDR_W;

    // --------------------------------------------------
    // encodings
    // --------------------------------------------------
    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_ADDIU = 6'h09,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B,
        OP_HALT  = 6'h3F                        // stops fetch, drains the pipe
    } opcodeE;

    // only meaningful with OP_RTYPE
    typedef enum logic [FUNCT_W-1:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } functE;

    // picked in decode, consumed in execute
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT                                 // signed compare
    } aluOpE;

endpackage

`default_nettype wire

/* common/cpuPipePkg.sv */
`default_nettype none

package cpuPipePkg;

    // --------------------------------------------------
    // memory sizes, both word addressed
    // --------------------------------------------------
    localparam int IMEM_WORDS  = 64;
    localparam int DMEM_WORDS  = 64;
    localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE,                               // register file value
        FWD_EXMEM,
        FWD_MEMWB
    } fwdSelE;

    // --------------------------------------------------
    // stage registers
    // --------------------------------------------------
    typedef struct packed {
        logic                           valid;
        logic [cpuIsaPkg::DATA_W-1:0]   instr;
    } ifIdT;

    typedef struct packed {
        logic                             valid;
        logic [cpuIsaPkg::REG_ADDR_W-1:0] rs;
        logic [cpuIsaPkg::REG_ADDR_W-1:0] rt;
        logic [cpuIsaPkg::REG_ADDR_W-1:0] dest;  // rd for R-type, rt otherwise
        logic [cpuIsaPkg::DATA_W-1:0]     opA;
        logic [cpuIsaPkg::DATA_W-1:0]     opB;
        logic [cpuIsaPkg::DATA_W-1:0]     imm;   // already sign extended
        cpuIsaPkg::aluOpE                 aluOp;
        logic                             useImm;
        logic                             memRead;
        logic                             memWrite;
        logic                             regWrite;
        logic                             halt;
    } idExT;

    typedef struct packed {
        logic                             valid;
        logic [cpuIsaPkg::DATA_W-1:0]     result;
        logic [cpuIsaPkg::DATA_W-1:0]     storeData;
        logic [cpuIsaPkg::REG_ADDR_W-1:0] dest;
        logic                             memRead;
        logic                             memWrite;
        logic                             regWrite;
        logic                             halt;
    } exMemT;

    // register file write, also the MEM/WB forward
    typedef struct packed {
        logic                             en;
        logic [cpuIsaPkg::REG_ADDR_W-1:0] dest;
        logic [cpuIsaPkg::DATA_W-1:0]     data;
    } wbWriteT;

endpackage

`default_nettype wire

/* design/instrFetch.sv */
`default_nettype none

module instrFetch (
    input  wire                               clk,
    input  wire                               i_reset,
    input  wire                               i_run,
    input  wire                               i_stall,
    input  wire                               i_haltSeen,
    input  wire                               i_instrWe,
    input  wire [cpuPipePkg::IMEM_ADDR_W-1:0] i_instrAddr,
    input  wire [cpuIsaPkg::DATA_W-1:0]       i_instrData,
    output cpuPipePkg::ifIdT                  o_ifId
);

    logic [cpuIsaPkg::DATA_W-1:0]       instrMem [cpuPipePkg::IMEM_WORDS];
    logic [cpuPipePkg::IMEM_ADDR_W-1:0] pc;
    logic [cpuIsaPkg::DATA_W-1:0]       instrQ;
    logic                               validQ;
    logic                               running;   // sticky once i_run seen
    logic                               stopped;   // sticky after HALT
    logic                               fetchEn;

    assign fetchEn = (i_run | running) & ~stopped & ~i_haltSeen;

    // load port, only used while idle
    always_ff @(posedge clk) begin
        if (i_instrWe) begin
            instrMem[i_instrAddr] <= i_instrData;
        end
    end

    // --------------------------------------------------
    // pc and IF/ID control
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc      <= '0;
            validQ  <= 1'b0;
            running <= 1'b0;
            stopped <= 1'b0;
        end else begin
            if (i_run) running <= 1'b1;
            if (i_haltSeen) stopped <= 1'b1;
            if (!i_stall) begin                 // stall freezes pc and IF/ID
                if (fetchEn) begin
                    pc     <= pc + 1'b1;        // one word per cycle
                    validQ <= 1'b1;
                end else begin
                    validQ <= 1'b0;
                end
            end
        end
    end

    // synchronous read is the IF/ID instruction register
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            instrQ <= instrMem[pc];
        end
    end

    assign o_ifId = '{valid: validQ, instr: instrQ};

endmodule

`default_nettype wire

/* decode/instrDecode.sv */
`default_nettype none

module instrDecode (
    input  wire                       clk,
    input  wire                       i_reset,
    input  wire cpuPipePkg::ifIdT     i_ifId,
    input  wire cpuPipePkg::wbWriteT  i_wb,
    output cpuPipePkg::idExT          o_idEx,
    output logic                      o_stall,
    output logic                      o_haltSeen
);

    logic [cpuIsaPkg::DATA_W-1:0]     regFile [cpuIsaPkg::REG_COUNT];
    logic [cpuIsaPkg::REG_ADDR_W-1:0] rs;
    logic [cpuIsaPkg::REG_ADDR_W-1:0] rt;
    logic [cpuIsaPkg::REG_ADDR_W-1:0] rd;
    logic [cpuIsaPkg::IMM_W-1:0]      immField;
    cpuIsaPkg::opcodeE                opcode;
    cpuIsaPkg::functE                 funct;
    cpuPipePkg::idExT                 idExD;
    cpuPipePkg::idExT                 idExQ;

    assign opcode   = cpuIsaPkg::opcodeE'(i_ifId.instr[31:26]);
    assign rs       = i_ifId.instr[25:21];
    assign rt       = i_ifId.instr[20:16];
    assign rd       = i_ifId.instr[15:11];
    assign immField = i_ifId.instr[cpuIsaPkg::IMM_W-1:0];
    assign funct    = cpuIsaPkg::functE'(i_ifId.instr[5:0]);

    // r0 is hard zero, same-cycle write passes straight through
    function automatic logic [cpuIsaPkg::DATA_W-1:0] readReg(
        input logic [cpuIsaPkg::REG_ADDR_W-1:0] idx
    );
        if (idx == '0) return '0;
        if (i_wb.en && i_wb.dest == idx) return i_wb.data;
        return regFile[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (i_wb.en && i_wb.dest != '0) begin
            regFile[i_wb.dest] <= i_wb.data;
        end
    end

    // --------------------------------------------------
    // hazards
    // --------------------------------------------------
    // load in EX feeding the instruction in ID
    assign o_stall = idExQ.valid && idExQ.memRead && idExQ.dest != '0 &&
                     i_ifId.valid && (idExQ.dest == rs || idExQ.dest == rt);

    assign o_haltSeen = i_ifId.valid && opcode == cpuIsaPkg::OP_HALT && !o_stall;

    // --------------------------------------------------
    // control decode
    // --------------------------------------------------
    always_comb begin
        idExD       = '0;
        idExD.valid = i_ifId.valid & ~o_stall;  // bubble on stall
        idExD.rs    = rs;
        idExD.rt    = rt;
        idExD.dest  = rt;
        idExD.opA   = readReg(rs);
        idExD.opB   = readReg(rt);
        idExD.imm   = {{(cpuIsaPkg::DATA_W - cpuIsaPkg::IMM_W){immField[cpuIsaPkg::IMM_W-1]}},
                       immField};
        idExD.aluOp = cpuIsaPkg::ALU_ADD;       // address math for LW/SW too
        case (opcode)
            cpuIsaPkg::OP_RTYPE: begin
                idExD.dest     = rd;
                idExD.regWrite = 1'b1;
                case (funct)
                    cpuIsaPkg::FN_ADDU: idExD.aluOp = cpuIsaPkg::ALU_ADD;
                    cpuIsaPkg::FN_SUBU: idExD.aluOp = cpuIsaPkg::ALU_SUB;
                    cpuIsaPkg::FN_AND:  idExD.aluOp = cpuIsaPkg::ALU_AND;
                    cpuIsaPkg::FN_OR:   idExD.aluOp = cpuIsaPkg::ALU_OR;
                    cpuIsaPkg::FN_SLT:  idExD.aluOp = cpuIsaPkg::ALU_SLT;
                    default:            idExD.regWrite = 1'b0;  // unknown funct is a nop
                endcase
            end
            cpuIsaPkg::OP_ADDIU: begin
                idExD.useImm   = 1'b1;
                idExD.regWrite = 1'b1;
            end
            cpuIsaPkg::OP_LW: begin
                idExD.useImm   = 1'b1;
                idExD.memRead  = 1'b1;
                idExD.regWrite = 1'b1;
            end
            cpuIsaPkg::OP_SW: begin
                idExD.useImm   = 1'b1;
                idExD.memWrite = 1'b1;
            end
            cpuIsaPkg::OP_HALT: idExD.halt = 1'b1;
            default: ;
        endcase
    end

    // ID/EX, flags are qualified by valid downstream
    always_ff @(posedge clk) begin
        idExQ <= idExD;
        if (i_reset) idExQ.valid <= 1'b0;
    end

    assign o_idEx = idExQ;

endmodule

`default_nettype wire

/* design/execute.sv */
`default_nettype none

module execute (
    input  wire                       clk,
    input  wire                       i_reset,
    input  wire cpuPipePkg::idExT     i_idEx,
    input  wire cpuPipePkg::wbWriteT  i_wb,
    output cpuPipePkg::exMemT         o_exMem
);

    cpuPipePkg::exMemT            exMemD;
    cpuPipePkg::exMemT            exMemQ;
    cpuPipePkg::fwdSelE           fwdA;
    cpuPipePkg::fwdSelE           fwdB;
    logic [cpuIsaPkg::DATA_W-1:0] opA;
    logic [cpuIsaPkg::DATA_W-1:0] opB;
    logic [cpuIsaPkg::DATA_W-1:0] aluB;
    logic [cpuIsaPkg::DATA_W-1:0] result;

    // --------------------------------------------------
    // forwarding
    // --------------------------------------------------
    // newer result wins; loads in EX/MEM never match thanks to the stall
    function automatic cpuPipePkg::fwdSelE pickFwd(
        input logic [cpuIsaPkg::REG_ADDR_W-1:0] src
    );
        if (src != '0 && exMemQ.valid && exMemQ.regWrite && !exMemQ.memRead &&
            exMemQ.dest == src) begin
            return cpuPipePkg::FWD_EXMEM;
        end
        if (src != '0 && i_wb.en && i_wb.dest == src) return cpuPipePkg::FWD_MEMWB;
        return cpuPipePkg::FWD_NONE;
    endfunction

    function automatic logic [cpuIsaPkg::DATA_W-1:0] fwdMux(
        input cpuPipePkg::fwdSelE           sel,
        input logic [cpuIsaPkg::DATA_W-1:0] regVal
    );
        case (sel)
            cpuPipePkg::FWD_EXMEM: return exMemQ.result;
            cpuPipePkg::FWD_MEMWB: return i_wb.data;
            default:               return regVal;
        endcase
    endfunction

    assign fwdA = pickFwd(i_idEx.rs);
    assign fwdB = pickFwd(i_idEx.rt);
    assign opA  = fwdMux(fwdA, i_idEx.opA);
    assign opB  = fwdMux(fwdB, i_idEx.opB);
    assign aluB = i_idEx.useImm ? i_idEx.imm : opB;

    // alu
    always_comb begin
        case (i_idEx.aluOp)
            cpuIsaPkg::ALU_ADD: result = opA + aluB;    // wraps
            cpuIsaPkg::ALU_SUB: result = opA - aluB;
            cpuIsaPkg::ALU_AND: result = opA & aluB;
            cpuIsaPkg::ALU_OR:  result = opA | aluB;
            cpuIsaPkg::ALU_SLT: result = {{(cpuIsaPkg::DATA_W-1){1'b0}},
                                          $signed(opA) < $signed(aluB)};
            default:            result = '0;
        endcase
    end

    always_comb begin
        exMemD.valid     = i_idEx.valid;
        exMemD.result    = result;
        exMemD.storeData = opB;                 // forwarded rt for SW
        exMemD.dest      = i_idEx.dest;
        exMemD.memRead   = i_idEx.valid & i_idEx.memRead;
        exMemD.memWrite  = i_idEx.valid & i_idEx.memWrite;
        exMemD.regWrite  = i_idEx.valid & i_idEx.regWrite;
        exMemD.halt      = i_idEx.valid & i_idEx.halt;
    end

    always_ff @(posedge clk) begin
        exMemQ <= exMemD;
        if (i_reset) exMemQ.valid <= 1'b0;
    end

    assign o_exMem = exMemQ;

endmodule

`default_nettype wire

/* design/memoryStage.sv */
`default_nettype none

module memoryStage (
    input  wire                               clk,
    input  wire                               i_reset,
    input  wire cpuPipePkg::exMemT            i_exMem,
    input  wire                               i_dbgReq,
    input  wire [cpuPipePkg::DMEM_ADDR_W-1:0] i_dbgAddr,
    output logic                              o_dbgAck,
    output logic [cpuIsaPkg::DATA_W-1:0]      o_dbgData,
    output cpuPipePkg::wbWriteT               o_wb,
    output logic                              o_halted
);

    typedef enum logic [1:0] {
        DBG_IDLE,
        DBG_READ,                               // read data lands this cycle
        DBG_ACK                                 // hold until req drops
    } dbgStateE;

    logic [cpuIsaPkg::DATA_W-1:0]       dataMem [cpuPipePkg::DMEM_WORDS];
    logic [cpuPipePkg::DMEM_ADDR_W-1:0] memAddr;
    logic [cpuPipePkg::DMEM_ADDR_W-1:0] rdAddr;
    logic [cpuIsaPkg::DATA_W-1:0]       rdData;
    logic [cpuIsaPkg::DATA_W-1:0]       dbgDataQ;
    dbgStateE                           dbgState;
    logic                               haltedQ;

    // MEM/WB
    logic                               wbValid;
    logic                               wbRegWrite;
    logic                               wbMemRead;
    logic                               wbHalt;
    logic [cpuIsaPkg::REG_ADDR_W-1:0]   wbDest;
    logic [cpuIsaPkg::DATA_W-1:0]       wbResult;

    assign memAddr = i_exMem.result[cpuPipePkg::DMEM_ADDR_W+1:2];  // byte addr, drop 2 lsbs
    assign rdAddr  = haltedQ ? i_dbgAddr : memAddr;   // pipe is empty once halted

    // --------------------------------------------------
    // data memory
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_exMem.valid && i_exMem.memWrite) begin
            dataMem[memAddr] <= i_exMem.storeData;
        end
        rdData <= dataMem[rdAddr];
    end

    always_ff @(posedge clk) begin
        wbRegWrite <= i_exMem.regWrite;
        wbMemRead  <= i_exMem.memRead;
        wbHalt     <= i_exMem.halt;
        wbDest     <= i_exMem.dest;
        wbResult   <= i_exMem.result;
        if (i_reset) wbValid <= 1'b0;
        else wbValid <= i_exMem.valid;
    end

    // write-back select
    assign o_wb = '{en:   wbValid & wbRegWrite,
                    dest: wbDest,
                    data: wbMemRead ? rdData : wbResult};

    always_ff @(posedge clk) begin
        if (i_reset) haltedQ <= 1'b0;
        else if (wbValid && wbHalt) haltedQ <= 1'b1;   // sticky until reset
    end

    // --------------------------------------------------
    // debug read, four-phase
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_reset) begin
            dbgState <= DBG_IDLE;
        end else begin
            case (dbgState)
                DBG_IDLE: if (i_dbgReq && haltedQ) dbgState <= DBG_READ;
                DBG_READ: dbgState <= DBG_ACK;
                DBG_ACK:  if (!i_dbgReq) dbgState <= DBG_IDLE;
                default:  dbgState <= DBG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dbgState == DBG_READ) dbgDataQ <= rdData;
    end

    assign o_dbgAck  = dbgState == DBG_ACK;
    assign o_dbgData = dbgDataQ;
    assign o_halted  = haltedQ;

endmodule

`default_nettype wire

/* design/mipsPipeline.sv */
`default_nettype none

module mipsPipeline (
    input  wire                               clk,
    input  wire                               i_reset,
    input  wire                               i_run,
    // program load, idle only
    input  wire                               i_instrWe,
    input  wire [cpuPipePkg::IMEM_ADDR_W-1:0] i_instrAddr,
    input  wire [cpuIsaPkg::DATA_W-1:0]       i_instrData,
    // debug read into data memory
    input  wire                               i_dbgReq,
    input  wire [cpuPipePkg::DMEM_ADDR_W-1:0] i_dbgAddr,
    output wire                               o_dbgAck,
    output wire [cpuIsaPkg::DATA_W-1:0]       o_dbgData,
    output wire                               o_halted
);

    cpuPipePkg::ifIdT    ifId;
    cpuPipePkg::idExT    idEx;
    cpuPipePkg::exMemT   exMem;
    cpuPipePkg::wbWriteT wb;     // regfile write and MEM/WB forward
    logic                stall;
    logic                haltSeen;

    // --------------------------------------------------
    // stage chain
    // --------------------------------------------------
    instrFetch u_instrFetch (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_run       (i_run),
        .i_stall     (stall),
        .i_haltSeen  (haltSeen),
        .i_instrWe   (i_instrWe),
        .i_instrAddr (i_instrAddr),
        .i_instrData (i_instrData),
        .o_ifId      (ifId)
    );

    instrDecode u_instrDecode (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_ifId     (ifId),
        .i_wb       (wb),
        .o_idEx     (idEx),
        .o_stall    (stall),      // load-use bubble
        .o_haltSeen (haltSeen)
    );

    execute u_execute (
        .clk     (clk),
        .i_reset (i_reset),
        .i_idEx  (idEx),
        .i_wb    (wb),
        .o_exMem (exMem)
    );

    memoryStage u_memoryStage (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_exMem   (exMem),
        .i_dbgReq  (i_dbgReq),
        .i_dbgAddr (i_dbgAddr),
        .o_dbgAck  (o_dbgAck),
        .o_dbgData (o_dbgData),
        .o_wb      (wb),
        .o_halted  (o_halted)
    );

endmodule

`default_nettype wire

/* testbench/tbPrograms.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

`default_nettype none

typedef logic [cpuIsaPkg::DATA_W-1:0]     wordT;
typedef logic [cpuIsaPkg::REG_ADDR_W-1:0] regIdxT;
typedef logic [cpuIsaPkg::IMM_W-1:0]      immT;

// --------------------------------------------------
// instruction encoders
// --------------------------------------------------
function automatic wordT encR(cpuIsaPkg::functE fn, regIdxT rd, regIdxT rs, regIdxT rt);
    return {cpuIsaPkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};     // shamt unused
endfunction

function automatic wordT encI(cpuIsaPkg::opcodeE op, regIdxT rt, regIdxT rs, immT imm);
    return {op, rs, rt, imm};
endfunction

function automatic wordT encHalt();
    return {cpuIsaPkg::OP_HALT, 26'd0};
endfunction

// --------------------------------------------------
// reference model
// --------------------------------------------------
function automatic wordT signExt(immT imm);
    return {{(cpuIsaPkg::DATA_W - cpuIsaPkg::IMM_W){imm[cpuIsaPkg::IMM_W-1]}}, imm};
endfunction

// 32-bit wrap-around, SLT compares signed
function automatic wordT refAlu(cpuIsaPkg::functE fn, wordT a, wordT b);
    case (fn)
        cpuIsaPkg::FN_ADDU: return a + b;
        cpuIsaPkg::FN_SUBU: return a - b;
        cpuIsaPkg::FN_AND:  return a & b;
        cpuIsaPkg::FN_OR:   return a | b;
        cpuIsaPkg::FN_SLT:  return ($signed(a) < $signed(b)) ? wordT'(1) : '0;
        default:            return '0;
    endcase
endfunction

// data memory word hit by a byte address
function automatic logic [cpuPipePkg::DMEM_ADDR_W-1:0] wordIndex(wordT byteAddr);
    return byteAddr[cpuPipePkg::DMEM_ADDR_W+1:2];
endfunction

function automatic wordT xorshift32(wordT x);
    wordT s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

`default_nettype wire

`endif

/* testbench/tbMipsPipeline.sv */
`include "tbPrograms.svh"

`default_nettype none

module tbMipsPipeline;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 10;
    localparam int HALT_TIMEOUT = 300;
    localparam int ACK_TIMEOUT  = 40;

    logic                               clk;
    logic                               i_reset;
    logic                               i_run;
    logic                               i_instrWe;
    logic [cpuPipePkg::IMEM_ADDR_W-1:0] i_instrAddr;
    wordT                               i_instrData;
    logic                               i_dbgReq;
    logic [cpuPipePkg::DMEM_ADDR_W-1:0] i_dbgAddr;
    logic                               o_dbgAck;
    wordT                               o_dbgData;
    logic                               o_halted;

    wordT progWords [$];
    wordT modelReg [cpuIsaPkg::REG_COUNT];
    wordT modelMem [cpuPipePkg::DMEM_WORDS];
    bit   expValid [cpuPipePkg::DMEM_WORDS];   // words the program stored
    wordT rngState;
    int   testErrors;
    int   errorCount;
    int   testsRun;
    int   testsClean;

    mipsPipeline u_mipsPipeline (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_run       (i_run),
        .i_instrWe   (i_instrWe),
        .i_instrAddr (i_instrAddr),
        .i_instrData (i_instrData),
        .i_dbgReq    (i_dbgReq),
        .i_dbgAddr   (i_dbgAddr),
        .o_dbgAck    (o_dbgAck),
        .o_dbgData   (o_dbgData),
        .o_halted    (o_halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // checks and bookkeeping
    // --------------------------------------------------
    function automatic void reportFailure(string name, string what);
        $display("** Error [%s] %s", name, what);
        testErrors++;
    endfunction

    function automatic void checkWord(string name, wordT expected, wordT actual);
        assert (actual === expected) else begin
            $display("** Error [%s] expected %h actual %h", name, expected, actual);
            testErrors++;
        end
    endfunction

    function automatic void finishTest(string name);
        testsRun++;
        if (testErrors == 0) testsClean++;
        $display("test %-9s done, %0d error(s)", name, testErrors);
        errorCount += testErrors;
        testErrors = 0;
    endfunction

    function automatic wordT nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // --------------------------------------------------
    // program builders that also update the model
    // --------------------------------------------------
    function automatic void clearModel();
        progWords.delete();
        foreach (modelReg[i]) modelReg[i] = '0;
        foreach (expValid[i]) expValid[i] = 1'b0;
    endfunction

    function automatic void emitR(cpuIsaPkg::functE fn, regIdxT rd, regIdxT rs, regIdxT rt);
        progWords.push_back(encR(fn, rd, rs, rt));
        if (rd != '0) modelReg[rd] = refAlu(fn, modelReg[rs], modelReg[rt]);
    endfunction

    function automatic void emitAddiu(regIdxT rt, regIdxT rs, immT imm);
        progWords.push_back(encI(cpuIsaPkg::OP_ADDIU, rt, rs, imm));
        if (rt != '0) modelReg[rt] = refAlu(cpuIsaPkg::FN_ADDU, modelReg[rs], signExt(imm));
    endfunction

    function automatic void emitSw(regIdxT rt, regIdxT rs, immT imm);
        logic [cpuPipePkg::DMEM_ADDR_W-1:0] word;
        word = wordIndex(modelReg[rs] + signExt(imm));
        progWords.push_back(encI(cpuIsaPkg::OP_SW, rt, rs, imm));
        modelMem[word] = modelReg[rt];
        expValid[word] = 1'b1;
    endfunction

    function automatic void emitLw(regIdxT rt, regIdxT rs, immT imm);
        logic [cpuPipePkg::DMEM_ADDR_W-1:0] word;
        word = wordIndex(modelReg[rs] + signExt(imm));
        progWords.push_back(encI(cpuIsaPkg::OP_LW, rt, rs, imm));
        if (rt != '0) modelReg[rt] = modelMem[word];
    endfunction

    // --------------------------------------------------
    // bus tasks
    // --------------------------------------------------
    task automatic applyReset();
        @(posedge clk);
        i_reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        i_reset <= 1'b0;
    endtask

    task automatic loadProgram();
        foreach (progWords[i]) begin
            @(posedge clk);
            i_instrWe   <= 1'b1;
            i_instrAddr <= 6'(i);
            i_instrData <= progWords[i];
        end
        @(posedge clk);
        i_instrWe <= 1'b0;
    endtask

    task automatic runProgram(string name, output bit ok);
        int cycles;
        applyReset();
        loadProgram();
        @(posedge clk);
        i_run <= 1'b1;
        @(posedge clk);
        i_run <= 1'b0;                          // fetch keeps going once started
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!o_halted && cycles < HALT_TIMEOUT);
        ok = o_halted;
        assert (ok) else reportFailure(name, "core did not halt before the timeout");
    endtask

    // four-phase read with the protocol checked on the way
    task automatic dbgRead(string name, logic [cpuPipePkg::DMEM_ADDR_W-1:0] addr,
                           output wordT data, output bit ok);
        int cycles;
        bit heldAfterDrop;
        @(negedge clk);
        assert (!o_dbgAck) else reportFailure(name, "ack was high before the request rose");
        @(posedge clk);
        i_dbgReq  <= 1'b1;
        i_dbgAddr <= addr;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!o_dbgAck && cycles < ACK_TIMEOUT);
        ok   = o_dbgAck;
        data = o_dbgData;
        @(posedge clk);
        i_dbgReq <= 1'b0;
        @(negedge clk);
        heldAfterDrop = o_dbgAck;               // drop not seen by the DUT yet
        cycles = 0;
        while (o_dbgAck && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (ok) else reportFailure(name, "debug read got no ack before the timeout");
        assert (!ok || heldAfterDrop) else reportFailure(name, "ack fell while request was high");
        assert (!o_dbgAck) else reportFailure(name, "ack stayed high after the request fell");
    endtask

    task automatic checkMemory(string name);
        wordT data;
        bit   ok;
        for (int w = 0; w < cpuPipePkg::DMEM_WORDS; w++) begin
            if (expValid[w]) begin
                dbgRead(name, 6'(w), data, ok);
                if (ok) checkWord(name, modelMem[w], data);
            end
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic testReset();
        string name = "reset";
        int    cycles;
        applyReset();
        repeat (5) begin
            @(negedge clk);
            assert (!o_halted && !o_dbgAck)
                else reportFailure(name, "halted or ack high while idle");
        end
        @(posedge clk);
        i_dbgReq  <= 1'b1;
        i_dbgAddr <= '0;
        for (cycles = 0; cycles < ACK_TIMEOUT; cycles++) begin
            @(negedge clk);
            assert (!o_dbgAck) else reportFailure(name, "debug read was served before halt");
        end
        @(posedge clk);
        i_dbgReq <= 1'b0;                       // withdraw the waiting request
        @(negedge clk);
        assert (!o_halted && !o_dbgAck) else reportFailure(name, "outputs high after withdraw");
        finishTest(name);
    endtask

    task automatic testChain();
        string name = "chain";
        bit    ok;
        clearModel();
        emitAddiu(5'd1, 5'd0, 16'h7FF0);
        emitAddiu(5'd2, 5'd1, 16'h8005);        // negative imm
        emitR(cpuIsaPkg::FN_ADDU, 5'd3, 5'd1, 5'd2);
        emitR(cpuIsaPkg::FN_SUBU, 5'd4, 5'd3, 5'd1);
        emitR(cpuIsaPkg::FN_AND,  5'd5, 5'd4, 5'd3);
        emitR(cpuIsaPkg::FN_OR,   5'd6, 5'd5, 5'd2);
        emitR(cpuIsaPkg::FN_SLT,  5'd7, 5'd6, 5'd5);   // negative vs positive
        emitR(cpuIsaPkg::FN_SLT,  5'd8, 5'd5, 5'd6);
        for (int r = 1; r <= 8; r++) begin
            emitSw(5'(r), 5'd0, 16'(4 * r));
        end
        progWords.push_back(encHalt());
        runProgram(name, ok);
        if (ok) checkMemory(name);
        finishTest(name);
    endtask

    task automatic testLoadUse();
        string name = "loaduse";
        bit    ok;
        clearModel();
        emitAddiu(5'd1, 5'd0, 16'h0123);
        emitAddiu(5'd2, 5'd0, 16'h0040);        // base of words 16..18
        emitSw(5'd1, 5'd2, 16'd0);
        emitLw(5'd3, 5'd2, 16'd0);
        emitR(cpuIsaPkg::FN_ADDU, 5'd4, 5'd3, 5'd1);   // uses the load right away
        emitSw(5'd4, 5'd2, 16'd4);
        emitLw(5'd5, 5'd2, 16'd4);
        emitSw(5'd5, 5'd2, 16'd8);              // store data straight from a load
        progWords.push_back(encHalt());
        runProgram(name, ok);
        if (ok) checkMemory(name);
        finishTest(name);
    endtask

    task automatic testRandom();
        string             name = "random";
        cpuIsaPkg::functE  ops [5];
        wordT              rnd;
        bit                ok;
        ops = '{cpuIsaPkg::FN_ADDU, cpuIsaPkg::FN_SUBU, cpuIsaPkg::FN_AND,
                cpuIsaPkg::FN_OR, cpuIsaPkg::FN_SLT};
        for (int round = 0; round < 4; round++) begin
            clearModel();
            rnd = nextRand();
            emitAddiu(5'd1, 5'd0, rnd[15:0]);
            rnd = nextRand();
            emitAddiu(5'd2, 5'd1, rnd[15:0]);
            for (int k = 0; k < 5; k++) begin
                rnd = nextRand();
                emitR(ops[int'(rnd % 32'd5)], 5'(3 + k), 5'(2 + k), 5'(1 + k));
            end
            rnd = nextRand();
            emitAddiu(5'd8, 5'd7, rnd[31:16]);
            for (int r = 1; r <= 8; r++) begin
                emitSw(5'(r), 5'd0, 16'(128 + 4 * r));  // words 33..40
            end
            progWords.push_back(encHalt());
            runProgram(name, ok);
            if (ok) checkMemory(name);
        end
        finishTest(name);
    endtask

    task automatic testHalt();
        string name = "halt";
        bit    ok;
        clearModel();
        emitAddiu(5'd1, 5'd0, 16'h55AA);
        emitSw(5'd1, 5'd0, 16'd176);            // word 44
        emitAddiu(5'd2, 5'd0, 16'hF00F);
        emitSw(5'd2, 5'd0, 16'd180);
        progWords.push_back(encHalt());
        // never executed since fetch stops at the HALT
        progWords.push_back(encI(cpuIsaPkg::OP_ADDIU, 5'd1, 5'd0, 16'h1111));
        progWords.push_back(encI(cpuIsaPkg::OP_SW, 5'd1, 5'd0, 16'd176));
        runProgram(name, ok);
        if (ok) checkMemory(name);
        repeat (3) begin
            @(negedge clk);
            assert (o_halted) else reportFailure(name, "halted flag dropped before reset");
        end
        finishTest(name);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        i_reset     = 1'b1;
        i_run       = 1'b0;
        i_instrWe   = 1'b0;
        i_instrAddr = '0;
        i_instrData = '0;
        i_dbgReq    = 1'b0;
        i_dbgAddr   = '0;
        rngState    = 32'd68;
        testErrors  = 0;
        errorCount  = 0;
        testsRun    = 0;
        testsClean  = 0;
        testReset();
        testChain();
        testLoadUse();
        testRandom();
        testHalt();
        $display("summary: %0d tests, %0d clean, %0d error(s)", testsRun, testsClean, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+testbench
common/cpuIsaPkg.sv
common/cpuPipePkg.sv
design/instrFetch.sv
decode/instrDecode.sv
design/execute.sv
design/memoryStage.sv
design/mipsPipeline.sv
testbench/tbMipsPipeline.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbMipsPipeline
BUILD_DIR ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) testbench/tbPrograms.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'ALL TESTS PASSED'

clean:
	rm -rf $(BUILD_DIR)
